// File: Makefile
.PHONY: compile run clean

compile: obj_dir/Vtb_pipeline

obj_dir/Vtb_pipeline: verilog.f *.sv
	verilator --binary --timing --assert -f verilog.f --top-module tb_pipeline -o Vtb_pipeline

run: obj_dir/Vtb_pipeline
	./obj_dir/Vtb_pipeline > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "test failed" sim.log; then exit 1; fi
	@grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: execute_alu.sv
`default_nettype none

module execute_alu (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          x_valid,
   input  wire x86_pipe_pkg::opcode_t   x_opcode,
   input  wire x86_pipe_pkg::reg_idx_t  x_dst,
   input  wire x86_pipe_pkg::word_t     x_op_a,
   input  wire x86_pipe_pkg::word_t     x_op_b,
   input  wire x86_pipe_pkg::imm_t      x_imm,
   input  wire x86_pipe_pkg::addr_t     x_pc,
   output logic                         x_ready,
   output logic                         ex_fwd_valid,
   output x86_pipe_pkg::reg_idx_t       ex_fwd_dst,
   output x86_pipe_pkg::word_t          ex_fwd_data,
   output logic                         w_valid,
   output x86_pipe_pkg::opcode_t        w_opcode,
   output x86_pipe_pkg::reg_idx_t       w_dst,
   output x86_pipe_pkg::word_t          w_result,
   output x86_pipe_pkg::addr_t          w_store_addr,
   output x86_pipe_pkg::addr_t          w_pc,
   input  wire                          w_ready
);

   x86_pipe_pkg::word_t alu_result;
   logic                writes_reg;

   always_comb begin
      case (x_opcode)
         x86_pipe_pkg::OP_MOVI: alu_result = x86_pipe_pkg::word_t'(x_imm);
         x86_pipe_pkg::OP_ADD:  alu_result = x_op_a + x_op_b;
         x86_pipe_pkg::OP_SUB:  alu_result = x_op_a - x_op_b;
         x86_pipe_pkg::OP_AND:  alu_result = x_op_a & x_op_b;
         x86_pipe_pkg::OP_OR:   alu_result = x_op_a | x_op_b;
         x86_pipe_pkg::OP_XOR:  alu_result = x_op_a ^ x_op_b;
         default:               alu_result = x_op_a;   // Store data
      endcase
   end

   assign writes_reg = (x_opcode >= x86_pipe_pkg::OP_MOVI) &&
                       (x_opcode <= x86_pipe_pkg::OP_XOR);

   assign ex_fwd_valid = x_valid && writes_reg;
   assign ex_fwd_dst   = x_dst;
   assign ex_fwd_data  = alu_result;

   assign x_ready = !w_valid || w_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         w_valid <= 1'b0;
      end else if (x_ready) begin
         w_valid <= x_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (x_valid && x_ready) begin
         w_opcode     <= x_opcode;
         w_dst        <= x_dst;
         w_result     <= alu_result;
         w_store_addr <= x86_pipe_pkg::addr_t'(x_imm);
         w_pc         <= x_pc;
      end
   end

endmodule

`default_nettype wire

// File: fetch_unit.sv
`default_nettype none

module fetch_unit #(
   parameter x86_pipe_pkg::addr_t RESET_PC = '0
) (
   input  wire                      clk,
   input  wire                      rst,
   output logic                     imem_valid,
   output x86_pipe_pkg::addr_t      imem_address,
   input  wire                      imem_ready,
   input  wire                      imem_dp_valid,
   input  wire x86_pipe_pkg::word_t imem_dp_read_data,
   output logic                     imem_dp_ready,
   output logic                     f_valid,
   output x86_pipe_pkg::word_t      f_instr,
   output x86_pipe_pkg::addr_t      f_pc,
   input  wire                      f_ready
);

   x86_pipe_pkg::fetch_state_e state;
   x86_pipe_pkg::addr_t        pc;

   assign imem_valid    = (state == x86_pipe_pkg::FETCH_REQ);
   assign imem_address  = pc;
   assign imem_dp_ready = (state == x86_pipe_pkg::FETCH_DATA);

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= x86_pipe_pkg::FETCH_HOLD;   // Empty hold, request next cycle
         pc      <= RESET_PC;
         f_valid <= 1'b0;
      end else begin
         case (state)
            x86_pipe_pkg::FETCH_REQ: begin
               if (imem_ready) begin
                  state <= x86_pipe_pkg::FETCH_DATA;
               end
            end
            x86_pipe_pkg::FETCH_DATA: begin
               if (imem_dp_valid) begin
                  state   <= x86_pipe_pkg::FETCH_HOLD;
                  f_valid <= 1'b1;
                  pc      <= pc + x86_pipe_pkg::INSTR_BYTES;
               end
            end
            x86_pipe_pkg::FETCH_HOLD: begin
               // Wait until the word moves into operand read
               if (!f_valid || f_ready) begin
                  state   <= x86_pipe_pkg::FETCH_REQ;
                  f_valid <= 1'b0;
               end
            end
            default: state <= x86_pipe_pkg::FETCH_REQ;
         endcase
      end
   end

   // Instruction register
   always_ff @(posedge clk) begin
      if (imem_dp_valid && imem_dp_ready) begin
         f_instr <= imem_dp_read_data;
         f_pc    <= pc;
      end
   end

   a_imem_addr_stable: assert property (@(posedge clk) disable iff (rst)
      imem_valid && !imem_ready |=> $stable(imem_address));

   a_dp_ready_not_in_req: assert property (@(posedge clk) disable iff (rst)
      state == x86_pipe_pkg::FETCH_REQ |-> !imem_dp_ready);

endmodule

`default_nettype wire

// File: operand_read.sv
`default_nettype none

module operand_read (
   input  wire                           clk,
   input  wire                           rst,
   input  wire                           f_valid,
   input  wire x86_pipe_pkg::word_t      f_instr,
   input  wire x86_pipe_pkg::addr_t      f_pc,
   output logic                          f_ready,
   input  wire                           ex_fwd_valid,
   input  wire x86_pipe_pkg::reg_idx_t   ex_fwd_dst,
   input  wire x86_pipe_pkg::word_t      ex_fwd_data,
   input  wire                           reg_wr_en,
   input  wire x86_pipe_pkg::reg_idx_t   reg_wr_idx,
   input  wire x86_pipe_pkg::word_t      reg_wr_data,
   output logic                          x_valid,
   output x86_pipe_pkg::opcode_t         x_opcode,
   output x86_pipe_pkg::reg_idx_t        x_dst,
   output x86_pipe_pkg::word_t           x_op_a,
   output x86_pipe_pkg::word_t           x_op_b,
   output x86_pipe_pkg::imm_t            x_imm,
   output x86_pipe_pkg::addr_t           x_pc,
   input  wire                           x_ready
);

   x86_pipe_pkg::word_t    regs [x86_pipe_pkg::NUM_REGS];
   x86_pipe_pkg::opcode_t  opcode;
   x86_pipe_pkg::reg_idx_t dst;
   x86_pipe_pkg::reg_idx_t src;
   x86_pipe_pkg::imm_t     imm;
   x86_pipe_pkg::word_t    op_a;
   x86_pipe_pkg::word_t    op_b;
   logic                   load;

   assign opcode = f_instr[x86_pipe_pkg::OPC_MSB:x86_pipe_pkg::OPC_LSB];
   assign dst    = f_instr[x86_pipe_pkg::DST_LSB +: $bits(x86_pipe_pkg::reg_idx_t)];
   assign src    = f_instr[x86_pipe_pkg::SRC_LSB +: $bits(x86_pipe_pkg::reg_idx_t)];
   assign imm    = f_instr[x86_pipe_pkg::IMM_LSB +: $bits(x86_pipe_pkg::imm_t)];

   assign f_ready = !x_valid || x_ready;
   assign load    = f_valid && f_ready;

   // Execute is newer than writeback, writeback newer than the file
   function automatic x86_pipe_pkg::word_t newest(input x86_pipe_pkg::reg_idx_t idx);
      if (ex_fwd_valid && ex_fwd_dst == idx) begin
         return ex_fwd_data;
      end else if (reg_wr_en && reg_wr_idx == idx) begin
         return reg_wr_data;
      end
      return regs[idx];
   endfunction

   always_comb begin
      op_a = newest(dst);
      op_b = newest(src);
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < x86_pipe_pkg::NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (reg_wr_en) begin
         regs[reg_wr_idx] <= reg_wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         x_valid <= 1'b0;
      end else if (f_ready) begin
         x_valid <= f_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         x_opcode <= opcode;
         x_dst    <= dst;
         x_op_a   <= op_a;
         x_op_b   <= op_b;
         x_imm    <= imm;
         x_pc     <= f_pc;
      end
   end

   a_x_valid_held: assert property (@(posedge clk) disable iff (rst)
      x_valid && !x_ready |=> x_valid);

endmodule

`default_nettype wire

// File: pipeline_golden.txt
// tag_aux_value  01 program word | 02 wmem_ready pattern, aux = length, value bits lsb first
// 03 expected store, aux = address, value = data | 04 expected retire count
01_000000_10001234   // movi eax, 0x1234
01_000000_70000100   // store eax at 0x100, eax from execute
01_000000_1200f00f   // movi ecx, 0xf00f
01_000000_140000ff   // movi edx, 0x00ff
01_000000_22800000   // add ecx, edx
01_000000_72000104   // store ecx at 0x104
01_000000_34400000   // sub edx, ecx
01_000000_74000108   // store edx at 0x108
01_000000_44400000   // and edx, ecx
01_000000_7400010c   // store edx at 0x10c
01_000000_52000000   // or ecx, eax
01_000000_72000110   // store ecx at 0x110
01_000000_60400000   // xor eax, ecx
01_000000_70000114   // store eax at 0x114
01_000000_f0000000   // opcode 15 acts as nop
01_000000_70000118   // store eax at 0x118
02_000007_0000004d
03_000100_00001234
03_000104_0000f10e
03_000108_ffff0ff1
03_00010c_00000100
03_000110_0000f33e
03_000114_0000e10a
03_000118_0000e10a
04_000000_00000010

// File: pipeline_top.sv
`default_nettype none

module pipeline_top #(
   parameter x86_pipe_pkg::addr_t RESET_PC = '0
) (
   input  wire                      clk,
   input  wire                      rst,
   output logic                     imem_valid,
   output x86_pipe_pkg::addr_t      imem_address,
   input  wire                      imem_ready,
   input  wire                      imem_dp_valid,
   input  wire x86_pipe_pkg::word_t imem_dp_read_data,
   output logic                     imem_dp_ready,
   output logic                     wmem_valid,
   output x86_pipe_pkg::addr_t      wmem_address,
   output x86_pipe_pkg::word_t      wmem_wr_data,
   input  wire                      wmem_ready,
   output logic                     retire_valid,
   output x86_pipe_pkg::addr_t      retire_pc,
   output x86_pipe_pkg::opcode_t    retire_opcode
);

   // Fetch to operand read
   wire                         f_valid;
   wire x86_pipe_pkg::word_t    f_instr;
   wire x86_pipe_pkg::addr_t    f_pc;
   wire                         f_ready;

   // Operand read to execute
   wire                         x_valid;
   wire x86_pipe_pkg::opcode_t  x_opcode;
   wire x86_pipe_pkg::reg_idx_t x_dst;
   wire x86_pipe_pkg::word_t    x_op_a;
   wire x86_pipe_pkg::word_t    x_op_b;
   wire x86_pipe_pkg::imm_t     x_imm;
   wire x86_pipe_pkg::addr_t    x_pc;
   wire                         x_ready;

   wire                         ex_fwd_valid;   // Execute bypass
   wire x86_pipe_pkg::reg_idx_t ex_fwd_dst;
   wire x86_pipe_pkg::word_t    ex_fwd_data;

   // Execute to writeback
   wire                         w_valid;
   wire x86_pipe_pkg::opcode_t  w_opcode;
   wire x86_pipe_pkg::reg_idx_t w_dst;
   wire x86_pipe_pkg::word_t    w_result;
   wire x86_pipe_pkg::addr_t    w_store_addr;
   wire x86_pipe_pkg::addr_t    w_pc;
   wire                         w_ready;

   wire                         reg_wr_en;      // Also writeback bypass
   wire x86_pipe_pkg::reg_idx_t reg_wr_idx;
   wire x86_pipe_pkg::word_t    reg_wr_data;

   fetch_unit #(.RESET_PC(RESET_PC)) fetch_unit_i (.*);

   operand_read operand_read_i (.*);

   execute_alu execute_alu_i (.*);

   writeback_unit writeback_unit_i (.*);

endmodule

`default_nettype wire

// File: tb_pipeline.sv
`default_nettype none

module tb_pipeline;

   logic                        clk = 1'b0;
   logic                        rst;
   logic                        imem_valid;
   x86_pipe_pkg::addr_t         imem_address;
   logic                        imem_ready;
   logic                        imem_dp_valid;
   x86_pipe_pkg::word_t         imem_dp_read_data;
   logic                        imem_dp_ready;
   logic                        wmem_valid;
   x86_pipe_pkg::addr_t         wmem_address;
   x86_pipe_pkg::word_t         wmem_wr_data;
   logic                        wmem_ready;
   logic                        retire_valid;
   x86_pipe_pkg::addr_t         retire_pc;
   x86_pipe_pkg::opcode_t       retire_opcode;

   logic [63:0]                 golden [0:63];   // Tag, aux, value
   x86_pipe_pkg::word_t         prog [0:31];
   x86_pipe_pkg::addr_t         st_addr [0:15];
   x86_pipe_pkg::word_t         st_data [0:15];
   logic [31:0]                 ready_pat;
   int                          ready_len;
   int                          prog_len;
   int                          n_stores;
   int                          exp_retire;
   int                          store_idx;
   int                          ret_idx;
   int                          checks;
   int                          cyc;
   int                          err_reset;
   int                          err_store;
   int                          err_retire;
   int                          req_wait;
   int                          resp_wait;
   integer                      seed = 89;
   logic                        pending;
   logic                        held;
   x86_pipe_pkg::addr_t         pend_addr;

   pipeline_top #(.RESET_PC(32'h0)) pipeline_top_i (.*);

   always #20 clk = ~clk;

   task automatic check_store(input x86_pipe_pkg::addr_t exp_addr,
                              input x86_pipe_pkg::word_t exp_data);
      checks++;
      if (wmem_address !== exp_addr) begin
         $display("ERR wmem_address expected %h got %h", exp_addr, wmem_address);
         err_store++;
      end
      if (wmem_wr_data !== exp_data) begin
         $display("ERR wmem_wr_data expected %h got %h", exp_data, wmem_wr_data);
         err_store++;
      end
   endtask

   task automatic check_retire(input x86_pipe_pkg::addr_t exp_pc,
                               input x86_pipe_pkg::opcode_t exp_opc);
      checks++;
      if (retire_pc !== exp_pc) begin
         $display("ERR retire_pc expected %h got %h", exp_pc, retire_pc);
         err_retire++;
      end
      if (retire_opcode !== exp_opc) begin
         $display("ERR retire_opcode expected %h got %h", exp_opc, retire_opcode);
         err_retire++;
      end
   endtask

   task automatic check_idle();
      checks++;
      if (imem_valid !== 1'b0) begin
         $display("ERR imem_valid expected 0 got %h", imem_valid);
         err_reset++;
      end
      if (imem_dp_ready !== 1'b0) begin
         $display("ERR imem_dp_ready expected 0 got %h", imem_dp_ready);
         err_reset++;
      end
      if (wmem_valid !== 1'b0) begin
         $display("ERR wmem_valid expected 0 got %h", wmem_valid);
         err_reset++;
      end
      if (retire_valid !== 1'b0) begin
         $display("ERR retire_valid expected 0 got %h", retire_valid);
         err_reset++;
      end
   endtask

   task automatic load_golden();
      logic [7:0]          tag;
      x86_pipe_pkg::word_t value;
      for (int i = 0; i < 64; i++) begin
         golden[i] = '0;
      end
      $readmemh("pipeline_golden.txt", golden);
      for (int i = 0; i < 64; i++) begin
         tag   = golden[i][63:56];
         value = golden[i][31:0];
         case (tag)
            8'h01: begin
               prog[prog_len] = value;
               prog_len++;
            end
            8'h02: begin
               ready_pat = value;
               ready_len = int'(golden[i][55:32]);
            end
            8'h03: begin
               st_addr[n_stores] = x86_pipe_pkg::addr_t'(golden[i][55:32]);
               st_data[n_stores] = value;
               n_stores++;
            end
            8'h04: exp_retire = int'(value);
            default: ;
         endcase
      end
   endtask

   task automatic run_watchdog(input int cycles);
      repeat (cycles) @(posedge clk);
      $display("timeout: pipeline did not finish within %0d cycles", cycles);
      $display("test failed");
      $finish;
   endtask

   // imem model and wmem sink, driven on the falling edge
   always @(negedge clk) begin
      int word_idx;
      imem_ready    = 1'b0;
      imem_dp_valid = 1'b0;
      wmem_ready    = 1'b0;
      if (!rst) begin
         if (imem_valid && !pending) begin
            if (req_wait == 0) begin
               imem_ready = 1'b1;
            end else begin
               req_wait--;
            end
         end
         if (pending) begin
            if (resp_wait == 0) begin
               word_idx          = int'(pend_addr >> 2);
               imem_dp_valid     = 1'b1;
               imem_dp_read_data = (word_idx < prog_len) ? prog[word_idx] : '0;   // NOP
            end else begin
               resp_wait--;
            end
         end
         wmem_ready = ((ready_pat >> (cyc % ready_len)) & 32'h1) != 0;
         cyc++;
      end
   end

   // Handshake monitor, values seen just before the edge
   always @(posedge clk) begin
      if (!rst) begin
         if (imem_valid && imem_ready) begin
            pending   = 1'b1;
            pend_addr = imem_address;
            resp_wait = $random(seed) & 3;
         end
         if (imem_dp_valid && imem_dp_ready) begin
            pending  = 1'b0;
            req_wait = $random(seed) & 3;
         end
         if (held && !wmem_valid) begin
            $display("a store was withdrawn before wmem accepted it");
            err_store++;
         end
         held = wmem_valid && !wmem_ready;
         if (wmem_valid) begin
            if (store_idx < n_stores) begin
               check_store(st_addr[store_idx], st_data[store_idx]);   // Also while held
            end else if (wmem_ready) begin
               $display("an extra store reached wmem at address %h", wmem_address);
               err_store++;
            end
            if (wmem_ready) begin
               store_idx++;
            end
         end
         if (retire_valid) begin
            if (ret_idx < prog_len) begin
               check_retire(x86_pipe_pkg::addr_t'(ret_idx * 4), prog[ret_idx][31:28]);
            end else begin
               check_retire(x86_pipe_pkg::addr_t'(ret_idx * 4), 4'h0);
            end
            ret_idx++;
         end
      end
   end

   initial begin
      rst               <= 1'b1;
      imem_ready        = 1'b0;
      imem_dp_valid     = 1'b0;
      imem_dp_read_data = '0;
      wmem_ready        = 1'b0;
      pending           = 1'b0;
      held              = 1'b0;
      ready_pat         = 32'h1;
      ready_len         = 1;
      load_golden();
      req_wait = $random(seed) & 3;
      fork
         run_watchdog((prog_len + n_stores) * 64);
      join_none
      repeat (4) begin
         @(negedge clk);
         check_idle();
      end
      rst <= 1'b0;
      @(posedge clk);
      check_idle();   // First cycle with rst low
      $display("reset_idle: %0d errors", err_reset);
      wait (store_idx >= n_stores);
      $display("stores: %0d of %0d in order, %0d errors", store_idx, n_stores, err_store);
      wait (ret_idx >= exp_retire);
      $display("retire: %0d of %0d in order, %0d errors", ret_idx, exp_retire, err_retire);
      repeat (8) @(posedge clk);
      $display("checks %0d, errors %0d", checks, err_reset + err_store + err_retire);
      if (err_reset + err_store + err_retire == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
x86_pipe_pkg.sv
fetch_unit.sv
operand_read.sv
execute_alu.sv
writeback_unit.sv
pipeline_top.sv
tb_pipeline.sv

// File: writeback_unit.sv
`default_nettype none

module writeback_unit (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          w_valid,
   input  wire x86_pipe_pkg::opcode_t   w_opcode,
   input  wire x86_pipe_pkg::reg_idx_t  w_dst,
   input  wire x86_pipe_pkg::word_t     w_result,
   input  wire x86_pipe_pkg::addr_t     w_store_addr,
   input  wire x86_pipe_pkg::addr_t     w_pc,
   output logic                         w_ready,
   output logic                         reg_wr_en,
   output x86_pipe_pkg::reg_idx_t       reg_wr_idx,
   output x86_pipe_pkg::word_t          reg_wr_data,
   output logic                         wmem_valid,
   output x86_pipe_pkg::addr_t          wmem_address,
   output x86_pipe_pkg::word_t          wmem_wr_data,
   input  wire                          wmem_ready,
   output logic                         retire_valid,
   output x86_pipe_pkg::addr_t          retire_pc,
   output x86_pipe_pkg::opcode_t        retire_opcode
);

   logic is_store;
   logic writes_reg;

   assign is_store   = (w_opcode == x86_pipe_pkg::OP_STORE);
   assign writes_reg = (w_opcode >= x86_pipe_pkg::OP_MOVI) &&
                       (w_opcode <= x86_pipe_pkg::OP_XOR);

   assign w_ready = !is_store || wmem_ready;   // Only a store can stall

   assign reg_wr_en   = w_valid && writes_reg;
   assign reg_wr_idx  = w_dst;
   assign reg_wr_data = w_result;

   assign wmem_valid   = w_valid && is_store;
   assign wmem_address = w_store_addr;
   assign wmem_wr_data = w_result;

   assign retire_valid  = w_valid && w_ready;
   assign retire_pc     = w_pc;
   assign retire_opcode = w_opcode;

   a_wr_or_store: assert property (@(posedge clk) disable iff (rst)
      !(reg_wr_en && wmem_valid));

   a_retire_has_valid: assert property (@(posedge clk) disable iff (rst)
      retire_valid |-> w_valid);

   // Held store must not change under back-pressure from wmem
   a_store_held: assert property (@(posedge clk) disable iff (rst)
      wmem_valid && !wmem_ready |=>
         wmem_valid && $stable(wmem_address) && $stable(wmem_wr_data));

endmodule

`default_nettype wire

// File: x86_pipe_pkg.sv
`default_nettype none

package x86_pipe_pkg;

   typedef logic [31:0] word_t;
   typedef logic [31:0] addr_t;
   typedef logic [2:0]  reg_idx_t;    // eax ecx edx ebx esp ebp esi edi
   typedef logic [3:0]  opcode_t;
   typedef logic [15:0] imm_t;

   // dst <= dst op src for ADD through XOR
   localparam opcode_t OP_NOP   = 4'd0;
   localparam opcode_t OP_MOVI  = 4'd1;   // dst <= zero-extended imm
   localparam opcode_t OP_ADD   = 4'd2;
   localparam opcode_t OP_SUB   = 4'd3;
   localparam opcode_t OP_AND   = 4'd4;
   localparam opcode_t OP_OR    = 4'd5;
   localparam opcode_t OP_XOR   = 4'd6;
   localparam opcode_t OP_STORE = 4'd7;   // wmem[imm] <= dst
   // 8 to 15 act as NOP

   // Instruction word layout
   localparam int OPC_MSB = 31;
   localparam int OPC_LSB = 28;
   localparam int DST_LSB = 25;
   localparam int SRC_LSB = 22;
   localparam int IMM_LSB = 0;

   localparam addr_t INSTR_BYTES = 32'd4;
   localparam int    NUM_REGS    = 8;

   typedef enum logic [1:0] {
      FETCH_REQ,
      FETCH_DATA,
      FETCH_HOLD
   } fetch_state_e;

endpackage

`default_nettype wire
